//--- Bender.yml
package:
  name: mlp_engine

sources:
  - files:
      - rtl/mlp_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/systolic_array.sv
      - rtl/output_stage.sv
      - rtl/mlp_controller.sv
      - rtl/mlp_top.sv

  - target: simulation
    files:
      - bench/tb_mlp_top.sv

//--- bench/tb_mlp_top.sv
`timescale 1ns/1ns

module tb_mlp_top;

    localparam int TIMEOUT_CYCLES = 100;

    logic                        clk;
    logic                        reset;
    logic                        wf_push_col0;
    logic                        wf_push_col1;
    mlp_pkg::act_t               wf_data;
    logic                        act_push;
    mlp_pkg::act_pair_t          act_data;
    logic                        start;
    logic signed [15:0]          norm_gain;
    mlp_pkg::acc_t               norm_bias;
    logic [mlp_pkg::SHIFT_W-1:0] norm_shift;
    mlp_pkg::act_t               q_zero_point;
    logic                        busy;
    logic                        result_valid;
    mlp_pkg::act_t               result0;
    mlp_pkg::act_t               result1;

    // What the host loaded, w_ref[row][col]
    int w_ref [2][2];
    int px0 [16];
    int px1 [16];
    int n_pairs;
    int seed = 32'hb09d3062;

    mlp_top dut0 (
        .clk(clk), .reset(reset),
        .wf_push_col0(wf_push_col0), .wf_push_col1(wf_push_col1), .wf_data(wf_data),
        .act_push(act_push), .act_data(act_data), .start(start),
        .norm_gain(norm_gain), .norm_bias(norm_bias), .norm_shift(norm_shift),
        .q_zero_point(q_zero_point), .busy(busy), .result_valid(result_valid),
        .result0(result0), .result1(result1)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Dot product per column, then gain, bias, shift, zero point and int8 clamp
    function automatic int expected_result(input int col);
        longint sum;
        longint norm;
        sum = 0;
        for (int i = 0; i < n_pairs; i++) begin
            sum += px0[i] * w_ref[0][col] + px1[i] * w_ref[1][col];
        end
        norm = sum * longint'(norm_gain) + longint'(norm_bias);
        norm = norm >>> norm_shift;
        norm = norm + longint'(q_zero_point);
        if (norm > 127) begin
            return 127;
        end
        if (norm < -128) begin
            return -128;
        end
        return int'(norm);
    endfunction

    function automatic int random_byte();
        logic [31:0] r;
        r = $random(seed);
        return $signed(r[7:0]);
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("Fail: time %0t, %s expected %0d, actual %0d", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic set_config(input int gain, input int bias, input int shift, input int zp);
        @(posedge clk);
        #2;
        norm_gain    = gain;
        norm_bias    = bias;
        norm_shift   = shift;
        q_zero_point = zp;
    endtask

    // First weight of each column lands in row 0
    task automatic load_weights(input int w00, input int w10, input int w01, input int w11);
        int vals [4];
        vals = '{w00, w10, w01, w11};
        w_ref[0][0] = w00;
        w_ref[1][0] = w10;
        w_ref[0][1] = w01;
        w_ref[1][1] = w11;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #2;
            wf_push_col0 = (i < 2);
            wf_push_col1 = (i >= 2);
            wf_data      = vals[i][7:0];
        end
        @(posedge clk);
        #2;
        wf_push_col0 = 1'b0;
        wf_push_col1 = 1'b0;
    endtask

    task automatic load_acts();
        for (int i = 0; i < n_pairs; i++) begin
            @(posedge clk);
            #2;
            act_push = 1'b1;
            act_data = {px1[i][7:0], px0[i][7:0]};
        end
        @(posedge clk);
        #2;
        act_push = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_value("busy", 1, busy);
    endtask

    // Returns at the falling edge where result_valid is high
    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!result_valid) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timeout: result_valid never rose after start at time %0t", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "timeout waiting for result_valid");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_inference();
        pulse_start();
        wait_result();
        check_value("busy", 0, busy);
        check_value("result0", expected_result(0), result0);
        check_value("result1", expected_result(1), result1);
        @(negedge clk);
        check_value("result_valid", 0, result_valid);
    endtask

    initial begin
        reset        = 1'b1;
        wf_push_col0 = 1'b0;
        wf_push_col1 = 1'b0;
        wf_data      = '0;
        act_push     = 1'b0;
        act_data     = '0;
        start        = 1'b0;
        norm_gain    = 16'sd1;
        norm_bias    = '0;
        norm_shift   = '0;
        q_zero_point = '0;
        n_pairs      = 0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("busy", 0, busy);
        check_value("result_valid", 0, result_valid);

        // Single pair, plain dot products
        set_config(1, 0, 0, 0);
        load_weights(1, 2, 3, 4);
        n_pairs = 1;
        px0[0] = 5;
        px1[0] = -3;
        load_acts();
        run_inference();
        check_value("result0", -1, result0);
        check_value("result1", 3, result1);

        // Full activation FIFO with random data
        set_config($random(seed) % 200, $random(seed) % 5000, 12 + ($random(seed) & 7),
                   $random(seed) % 20);
        load_weights(random_byte(), random_byte(), random_byte(), random_byte());
        n_pairs = 16;
        for (int i = 0; i < 16; i++) begin
            px0[i] = random_byte();
            px1[i] = random_byte();
        end
        load_acts();
        run_inference();

        // Nothing to stream, bias path only
        set_config(3, -600, 3, -10);
        load_weights(7, -7, 9, 2);
        n_pairs = 0;
        run_inference();
        check_value("result0", -85, result0);
        check_value("result1", -85, result1);

        // Saturation in both directions
        set_config(1, 0, 0, 0);
        load_weights(127, 127, -128, -128);
        n_pairs = 4;
        for (int i = 0; i < 4; i++) begin
            px0[i] = 127;
            px1[i] = 127;
        end
        load_acts();
        run_inference();
        check_value("result0", 127, result0);
        check_value("result1", -128, result1);

        // Back to back, second run must not see the first sums
        set_config(2, 4, 1, 3);
        load_weights(2, 1, -1, 3);
        n_pairs = 3;
        // Nonzero sums left behind in both columns
        for (int i = 0; i < 3; i++) begin
            px0[i] = 3;
            px1[i] = 2;
        end
        load_acts();
        run_inference();
        check_value("result0", 29, result0);
        check_value("result1", 14, result1);
        load_weights(5, -2, 4, 1);
        n_pairs = 4;
        // Small values keep the second result clear of saturation
        for (int i = 0; i < 4; i++) begin
            px0[i] = random_byte() % 4;
            px1[i] = random_byte() % 4;
        end
        load_acts();
        pulse_start();
        // Second start lands in the middle of the run
        repeat (3) @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_result();
        check_value("busy", 0, busy);
        check_value("result0", expected_result(0), result0);
        check_value("result1", expected_result(1), result1);
        for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
            @(negedge clk);
            check_value("result_valid", 0, result_valid);
            check_value("result0", expected_result(0), result0);
            check_value("result1", expected_result(1), result1);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/mlp_controller.sv
`timescale 1ns/1ns

module mlp_controller (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic act_empty,
    output logic weight_pop,
    output logic weight_load,
    output logic act_pop,
    output logic acc_clear,
    output logic finish,
    output logic busy
);

    mlp_pkg::ctrl_state_t state;

    // Shared by the weight load and drain phases
    logic [$clog2(mlp_pkg::WEIGHT_DEPTH + mlp_pkg::DRAIN_CYCLES)-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mlp_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                mlp_pkg::IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state <= mlp_pkg::LOAD_WEIGHT;
                    end
                end
                // One weight per column per cycle
                mlp_pkg::LOAD_WEIGHT: begin
                    if (int'(cnt) == mlp_pkg::WEIGHT_DEPTH - 1) begin
                        cnt <= '0;
                        if (act_empty) begin
                            state <= mlp_pkg::DRAIN;
                        end else begin
                            state <= mlp_pkg::COMPUTE;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                mlp_pkg::COMPUTE: begin
                    if (act_empty) begin
                        state <= mlp_pkg::DRAIN;
                    end
                end
                // Let the last pairs leave the array and reach the accumulators
                mlp_pkg::DRAIN: begin
                    if (int'(cnt) == mlp_pkg::DRAIN_CYCLES - 1) begin
                        cnt   <= '0;
                        state <= mlp_pkg::FINISH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                mlp_pkg::FINISH: begin
                    state <= mlp_pkg::IDLE;
                end
                default: begin
                    state <= mlp_pkg::IDLE;
                end
            endcase
        end
    end

    assign weight_pop  = (state == mlp_pkg::LOAD_WEIGHT);
    assign weight_load = (state == mlp_pkg::LOAD_WEIGHT);
    assign act_pop     = (state == mlp_pkg::COMPUTE) && !act_empty;
    // Clear pulse in the cycle start is taken
    assign acc_clear   = (state == mlp_pkg::IDLE) && start;
    assign finish      = (state == mlp_pkg::FINISH);
    assign busy        = (state != mlp_pkg::IDLE);

endmodule

//--- rtl/mlp_pkg.sv
package mlp_pkg;

    // Datapath widths
    localparam int ACT_W   = 8;
    localparam int ACC_W   = 32;
    localparam int NORM_W  = 64;
    localparam int SHIFT_W = 5;

    // Buffer depths
    localparam int ACT_DEPTH    = 16;
    localparam int WEIGHT_DEPTH = 2;

    // Pipeline timing
    localparam int ARRAY_LATENCY = 2;
    localparam int DRAIN_CYCLES  = 3;

    typedef logic signed [ACT_W-1:0] act_t;

    // Low byte is x0 for row 0 and high byte is x1 for row 1
    typedef logic [2*ACT_W-1:0] act_pair_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    typedef enum logic [2:0] {
        IDLE, LOAD_WEIGHT, COMPUTE, DRAIN, FINISH
    } ctrl_state_t;

endpackage

//--- rtl/mlp_top.sv
`timescale 1ns/1ns

module mlp_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wf_push_col0,
    input  logic                        wf_push_col1,
    input  mlp_pkg::act_t               wf_data,
    input  logic                        act_push,
    input  mlp_pkg::act_pair_t          act_data,
    input  logic                        start,
    input  logic signed [15:0]          norm_gain,
    input  mlp_pkg::acc_t               norm_bias,
    input  logic [mlp_pkg::SHIFT_W-1:0] norm_shift,
    input  mlp_pkg::act_t               q_zero_point,
    output logic                        busy,
    output logic                        result_valid,
    output mlp_pkg::act_t               result0,
    output mlp_pkg::act_t               result1
);

    mlp_pkg::act_t      w_col0;
    mlp_pkg::act_t      w_col1;
    mlp_pkg::act_pair_t act_pair;
    mlp_pkg::acc_t      psum0;
    mlp_pkg::acc_t      psum1;
    logic               psum_valid;
    logic               act_empty;
    logic               weight_pop;
    logic               weight_load;
    logic               act_pop;
    logic               acc_clear;
    logic               finish;

    // Column weight buffers, popped together during the load phase
    sync_fifo #(.item_t(mlp_pkg::act_t), .DEPTH(mlp_pkg::WEIGHT_DEPTH)) weight_fifo0 (
        .clk(clk), .reset(reset),
        .push(wf_push_col0), .push_data(wf_data),
        .pop(weight_pop), .pop_data(w_col0), .empty()
    );

    sync_fifo #(.item_t(mlp_pkg::act_t), .DEPTH(mlp_pkg::WEIGHT_DEPTH)) weight_fifo1 (
        .clk(clk), .reset(reset),
        .push(wf_push_col1), .push_data(wf_data),
        .pop(weight_pop), .pop_data(w_col1), .empty()
    );

    sync_fifo #(.item_t(mlp_pkg::act_pair_t), .DEPTH(mlp_pkg::ACT_DEPTH)) act_fifo (
        .clk(clk), .reset(reset),
        .push(act_push), .push_data(act_data),
        .pop(act_pop), .pop_data(act_pair), .empty(act_empty)
    );

    systolic_array u_array (
        .clk(clk), .reset(reset),
        .weight_load(weight_load), .w_col0(w_col0), .w_col1(w_col1),
        .valid_in(act_pop), .act_pair(act_pair),
        .psum0(psum0), .psum1(psum1), .psum_valid(psum_valid)
    );

    output_stage u_output (
        .clk(clk), .reset(reset),
        .acc_clear(acc_clear), .psum0(psum0), .psum1(psum1), .psum_valid(psum_valid),
        .finish(finish), .norm_gain(norm_gain), .norm_bias(norm_bias),
        .norm_shift(norm_shift), .q_zero_point(q_zero_point),
        .result0(result0), .result1(result1), .result_valid(result_valid)
    );

    mlp_controller u_ctrl (
        .clk(clk), .reset(reset),
        .start(start), .act_empty(act_empty),
        .weight_pop(weight_pop), .weight_load(weight_load), .act_pop(act_pop),
        .acc_clear(acc_clear), .finish(finish), .busy(busy)
    );

endmodule

//--- rtl/output_stage.sv
`timescale 1ns/1ns

module output_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       acc_clear,
    input  mlp_pkg::acc_t              psum0,
    input  mlp_pkg::acc_t              psum1,
    input  logic                       psum_valid,
    input  logic                       finish,
    input  logic signed [15:0]         norm_gain,
    input  mlp_pkg::acc_t              norm_bias,
    input  logic [mlp_pkg::SHIFT_W-1:0] norm_shift,
    input  mlp_pkg::act_t              q_zero_point,
    output mlp_pkg::act_t              result0,
    output mlp_pkg::act_t              result1,
    output logic                       result_valid
);

    mlp_pkg::acc_t acc0;
    mlp_pkg::acc_t acc1;

    // Scale, bias, shift, then offset and clamp to int8
    function automatic mlp_pkg::act_t requantize(input mlp_pkg::acc_t acc);
        logic signed [mlp_pkg::NORM_W-1:0] norm;
        norm = acc * norm_gain;
        norm = norm + norm_bias;
        norm = norm >>> norm_shift;
        norm = norm + q_zero_point;
        if (norm > 127) begin
            return 8'sd127;
        end else if (norm < -128) begin
            return -8'sd128;
        end
        return mlp_pkg::act_t'(norm[mlp_pkg::ACT_W-1:0]);
    endfunction

    always_ff @(posedge clk) begin
        if (reset || acc_clear) begin
            acc0 <= '0;
            acc1 <= '0;
        end else if (psum_valid) begin
            acc0 <= acc0 + psum0;
            acc1 <= acc1 + psum1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= finish;
        end
    end

    // Results hold until the next finish
    always_ff @(posedge clk) begin
        if (finish) begin
            result0 <= requantize(acc0);
            result1 <= requantize(acc1);
        end
    end

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_data,
    input  logic  pop,
    output item_t pop_data,
    output logic  empty
);

    item_t                        mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         full;
    logic                         do_push;
    logic                         do_pop;

    assign empty   = (count == '0);
    assign full    = (int'(count) == DEPTH);
    // Pushes into a full buffer are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read of the head entry
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/systolic_array.sv
`timescale 1ns/1ns

module systolic_array (
    input  logic               clk,
    input  logic               reset,
    input  logic               weight_load,
    input  mlp_pkg::act_t      w_col0,
    input  mlp_pkg::act_t      w_col1,
    input  logic               valid_in,
    input  mlp_pkg::act_pair_t act_pair,
    output mlp_pkg::acc_t      psum0,
    output mlp_pkg::acc_t      psum1,
    output logic               psum_valid
);

    // Stationary weights, indexed by column
    mlp_pkg::act_t w_row0 [2];
    mlp_pkg::act_t w_row1 [2];

    mlp_pkg::act_t x0;
    mlp_pkg::act_t x1;
    mlp_pkg::act_t x1_skew;
    mlp_pkg::acc_t row0_psum [2];
    mlp_pkg::acc_t row1_psum [2];

    logic [mlp_pkg::ARRAY_LATENCY-1:0] valid_sr;

    assign x0 = mlp_pkg::act_t'(act_pair[mlp_pkg::ACT_W-1:0]);
    assign x1 = mlp_pkg::act_t'(act_pair[2*mlp_pkg::ACT_W-1:mlp_pkg::ACT_W]);

    // Weights enter at row 1 and move up, so the first one pushed ends in row 0
    always_ff @(posedge clk) begin
        if (weight_load) begin
            w_row0[0] <= w_row1[0];
            w_row0[1] <= w_row1[1];
            w_row1[0] <= w_col0;
            w_row1[1] <= w_col1;
        end
    end

    always_ff @(posedge clk) begin
        // Row 0 product, x1 delayed one cycle to meet its row-0 sum
        if (valid_in) begin
            x1_skew <= x1;
            for (int j = 0; j < 2; j++) begin
                row0_psum[j] <= x0 * w_row0[j];
            end
        end
        // Row 1 adds its product onto the sum coming down the column
        if (valid_sr[0]) begin
            for (int j = 0; j < 2; j++) begin
                row1_psum[j] <= row0_psum[j] + x1_skew * w_row1[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[mlp_pkg::ARRAY_LATENCY-2:0], valid_in};
        end
    end

    assign psum0      = row1_psum[0];
    assign psum1      = row1_psum[1];
    assign psum_valid = valid_sr[mlp_pkg::ARRAY_LATENCY-1];

endmodule

//--- sources.f
rtl/mlp_pkg.sv
rtl/sync_fifo.sv
rtl/systolic_array.sv
rtl/output_stage.sv
rtl/mlp_controller.sv
rtl/mlp_top.sv
bench/tb_mlp_top.sv
